//--- shiftPkg.sv
// 16-bit words only and no arithmetic right shift, op codes follow the shifter mux order
package shiftPkg;

  // Datapath widths
  localparam int WordWidth = 16;
  localparam int OpWidth   = 2;
  localparam int AmtWidth  = 4;

  // Data operand and shift result
  typedef logic [WordWidth-1:0] wordT;

  // Operation code
  typedef logic [OpWidth-1:0] shiftOpT;

  // Shift amount, 0 to 15
  typedef logic [AmtWidth-1:0] shiftAmtT;

  // Operation encodings
  // Rotate left
  localparam shiftOpT OpRotL   = 2'b00;
  // Shift left, zero fill from bit 0
  localparam shiftOpT OpShiftL = 2'b01;
  // Rotate right
  localparam shiftOpT OpRotR   = 2'b10;
  // Logical shift right, zero fill from the top bit
  localparam shiftOpT OpShiftR = 2'b11;

  // Input strobe to output strobe, in clock cycles
  // Issue, register A, register B and retire
  localparam int PipeLatency = 4;

endpackage

//--- shiftBus.sv
// Data fields are only meaningful while vld is high, and vld is never held back
`timescale 1ns/1ps

interface shiftBus
  import shiftPkg::*;
();

  // One-cycle strobe per operation
  logic     vld;

  // Operand or partially shifted value
  wordT     value;

  // Operation code, carried along with the data
  shiftOpT  op;

  // Original shift amount
  // Not needed downstream of the shifter
  shiftAmtT amt;

  // Producer side
  modport src (
    output vld, value, op, amt
  );

  // Consumer side
  modport dst (
    input vld, value, op, amt
  );

endinterface

//--- shiftStage.sv
// Dist must lie between 1 and WordWidth-1, the stage is purely combinational
`timescale 1ns/1ps

module shiftStage
  import shiftPkg::*;
#(
  // Fixed shift distance of this stage
  parameter int Dist = 1
) (
  input  wordT    inValue,
  input  shiftOpT op,
  input  logic    sel,
  output wordT    outValue
);

  // Result of the selected operation by Dist
  wordT shifted;

  always_comb begin
    shifted = inValue;
    case (op)
      OpRotL: begin
        // Top bits wrap into the bottom
        shifted = (inValue << Dist) | (inValue >> (WordWidth - Dist));
      end
      OpShiftL: begin
        shifted = inValue << Dist;
      end
      OpRotR: begin
        // Bottom bits wrap into the top
        shifted = (inValue >> Dist) | (inValue << (WordWidth - Dist));
      end
      OpShiftR: begin
        // Logical, so no sign fill
        shifted = inValue >> Dist;
      end
      default: begin
        shifted = inValue;
      end
    endcase
  end

  // Pass through unchanged when this amount bit is clear
  assign outValue = sel ? shifted : inValue;

endmodule

//--- shiftIssue.sv
// Operands are captured only on a strobe, so idle cycles hold the last operation
`timescale 1ns/1ps

module shiftIssue
  import shiftPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  logic     inVld,
  input  wordT     inValue,
  input  shiftOpT  inOp,
  input  shiftAmtT inAmt,
  shiftBus.src     issue
);

  // Strobe is sampled every cycle
  // No back-pressure, so nothing can hold it
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      issue.vld <= 1'b0;
    end else begin
      issue.vld <= inVld;
    end
  end

  // Operand capture
  // Isolates top-level input timing from the first shift stages
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      issue.value <= '0;
      issue.op    <= OpRotL;
      issue.amt   <= '0;
    end else if (inVld) begin
      issue.value <= inValue;
      issue.op    <= inOp;
      issue.amt   <= inAmt;
    end
  end

endmodule

//--- shiftPipe.sv
// Two register stages, each after a pair of shift stages, with one operation accepted per cycle
`timescale 1ns/1ps

module shiftPipe
  import shiftPkg::*;
(
  input  logic clk,
  input  logic rstN,
  shiftBus.dst up,
  shiftBus.src down
);

  // Between stage 1 and stage 2
  wordT     by1Value;
  // Into register A
  wordT     by2Value;

  // Register A
  logic     aVld;
  wordT     aValue;
  shiftOpT  aOp;
  // Upper bits drive the 4 and 8 stages
  // Lower bits only ride along for the downstream amt field
  shiftAmtT aAmt;

  // After stage 4
  wordT     by4Value;
  // Final value into register B
  wordT     by8Value;

  // First half, distances 1 and 2
  shiftStage #(.Dist(1)) i_stage1 (
    .inValue (up.value),
    .op      (up.op),
    .sel     (up.amt[0]),
    .outValue(by1Value)
  );

  shiftStage #(.Dist(2)) i_stage2 (
    .inValue (by1Value),
    .op      (up.op),
    .sel     (up.amt[1]),
    .outValue(by2Value)
  );

  // Register A
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aVld   <= 1'b0;
      aValue <= '0;
      aOp    <= OpRotL;
      aAmt   <= '0;
    end else begin
      aVld <= up.vld;
      if (up.vld) begin
        aValue <= by2Value;
        aOp    <= up.op;
        aAmt   <= up.amt;
      end
    end
  end

  // Second half, distances 4 and 8
  shiftStage #(.Dist(4)) i_stage4 (
    .inValue (aValue),
    .op      (aOp),
    .sel     (aAmt[2]),
    .outValue(by4Value)
  );

  shiftStage #(.Dist(8)) i_stage8 (
    .inValue (by4Value),
    .op      (aOp),
    .sel     (aAmt[3]),
    .outValue(by8Value)
  );

  // Register B, drives the retire side
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      down.vld   <= 1'b0;
      down.value <= '0;
      down.op    <= OpRotL;
      down.amt   <= '0;
    end else begin
      down.vld <= aVld;
      if (aVld) begin
        down.value <= by8Value;
        down.op    <= aOp;
        down.amt   <= aAmt;
      end
    end
  end

endmodule

//--- shiftRetire.sv
// Flags are decoded from the registered result and are valid only while outVld is high
`timescale 1ns/1ps

module shiftRetire
  import shiftPkg::*;
(
  input  logic clk,
  input  logic rstN,
  shiftBus.dst res,
  output logic outVld,
  output wordT outValue,
  output logic outZero,
  output logic outNeg
);

  // Result strobe, one per issued operation
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outVld <= 1'b0;
    end else begin
      outVld <= res.vld;
    end
  end

  // Result value
  // Held between strobes
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValue <= '0;
    end else if (res.vld) begin
      outValue <= res.value;
    end
  end

  // Zero flag, whole word clear
  assign outZero = (outValue == '0);

  // Negative flag is just the top bit
  assign outNeg = outValue[WordWidth-1];

endmodule

//--- shiftUnit.sv
// Fixed latency of PipeLatency cycles with no stall input, so every strobe returns exactly once
`timescale 1ns/1ps

module shiftUnit
  import shiftPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  logic     inVld,
  input  wordT     inValue,
  input  shiftOpT  inOp,
  input  shiftAmtT inAmt,
  output logic     outVld,
  output wordT     outValue,
  output logic     outZero,
  output logic     outNeg
);

  // Issue register to shifter
  shiftBus issueBus ();
  // Shifter to retire stage
  shiftBus pipeBus ();

  shiftIssue i_shiftIssue (
    .clk    (clk),
    .rstN   (rstN),
    .inVld  (inVld),
    .inValue(inValue),
    .inOp   (inOp),
    .inAmt  (inAmt),
    .issue  (issueBus.src)
  );

  // Two cycles through the barrel shifter
  shiftPipe i_shiftPipe (
    .clk (clk),
    .rstN(rstN),
    .up  (issueBus.dst),
    .down(pipeBus.src)
  );

  shiftRetire i_shiftRetire (
    .clk     (clk),
    .rstN    (rstN),
    .res     (pipeBus.dst),
    .outVld  (outVld),
    .outValue(outValue),
    .outZero (outZero),
    .outNeg  (outNeg)
  );

endmodule

//--- shiftUnit_props.sv
// Covers strobe timing, zero flag and reset only, result data is left to the testbench model
`timescale 1ns/1ps

module shiftUnitProps
  import shiftPkg::*;
(
  input logic clk,
  input logic rstN,
  input logic inVld,
  input logic outVld,
  input wordT outValue,
  input logic outZero
);

  // Each strobe returns after exactly PipeLatency edges, no extra pulses
  property fixedLatency;
    @(posedge clk) disable iff (!rstN)
      outVld == $past(inVld, PipeLatency);
  endproperty

  // Zero flag tracks the result word
  property zeroFlag;
    @(posedge clk) disable iff (!rstN)
      outVld |-> (outZero == (outValue == '0));
  endproperty

  // Output strobe held off during reset
  property quietInReset;
    @(posedge clk) !rstN |-> !outVld;
  endproperty

  assert property (fixedLatency) else $error("outVld does not follow inVld by PipeLatency");
  assert property (zeroFlag) else $error("outZero disagrees with outValue");
  assert property (quietInReset) else $error("outVld high during reset");

endmodule

bind shiftUnit shiftUnitProps i_shiftUnitProps (.*);

//--- shiftUnit_tb.sv
// Drives 1 ns after the rising edge and compares at the falling edge, expects PipeLatency cycles
`timescale 1ns/1ps

module shiftUnit_tb
  import shiftPkg::*;
();

  // Cycles allowed for any single wait
  localparam int WaitLimit = 50;

  logic     clk;
  logic     rstN;
  logic     inVld;
  wordT     inValue;
  shiftOpT  inOp;
  shiftAmtT inAmt;
  logic     outVld;
  wordT     outValue;
  logic     outZero;
  logic     outNeg;

  // Expected {neg, zero, value}, oldest first
  logic [WordWidth+1:0] expQ[$];

  int issued = 0;
  int checked = 0;
  int errValue = 0;
  int errFlag = 0;
  int errOther = 0;

  shiftUnit i_shiftUnit (
    .clk     (clk),
    .rstN    (rstN),
    .inVld   (inVld),
    .inValue (inValue),
    .inOp    (inOp),
    .inAmt   (inAmt),
    .outVld  (outVld),
    .outValue(outValue),
    .outZero (outZero),
    .outNeg  (outNeg)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // Bit-by-bit model of the four operations
  function automatic wordT refShift(input wordT value, input shiftOpT op, input shiftAmtT amt);
    wordT res;
    res = '0;
    for (int i = 0; i < WordWidth; i++) begin
      case (op)
        OpRotL: res[(i + amt) % WordWidth] = value[i];
        OpShiftL: if (i + amt < WordWidth) res[i + amt] = value[i];
        OpRotR: res[i] = value[(i + amt) % WordWidth];
        default: if (i + amt < WordWidth) res[i] = value[i + amt];
      endcase
    end
    return res;
  endfunction

  // One strobe with a given expectation, returns 1 ns after the next edge
  task automatic driveExpect(input wordT value, input shiftOpT op, input shiftAmtT amt,
                             input wordT exp);
    inVld   = 1'b1;
    inValue = value;
    inOp    = op;
    inAmt   = amt;
    expQ.push_back({exp[WordWidth-1], exp == '0, exp});
    issued++;
    @(posedge clk);
    #1;
    inVld = 1'b0;
  endtask

  task automatic driveOp(input wordT value, input shiftOpT op, input shiftAmtT amt);
    driveExpect(value, op, amt, refShift(value, op, amt));
  endtask

  // Idle cycles carry junk operands that must be ignored
  task automatic idleCycles(input int n);
    repeat (n) begin
      inVld   = 1'b0;
      inValue = wordT'($urandom);
      inOp    = shiftOpT'($urandom);
      inAmt   = shiftAmtT'($urandom);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic waitDrain();
    int cycles;
    cycles = 0;
    while (expQ.size() != 0 && cycles < WaitLimit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (expQ.size() != 0) begin
      errOther++;
      $display("ERROR at %0t: timed out waiting for %0d outstanding results", $time, expQ.size());
    end
  endtask

  // Single strobe, counts edges until outVld rises
  task automatic checkLatency(input wordT value, input shiftOpT op, input shiftAmtT amt);
    int cycles;
    // The cycle with the strobe on inVld is the first one
    cycles = 1;
    driveOp(value, op, amt);
    while (!outVld && cycles < WaitLimit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!outVld) begin
      errOther++;
      $display("ERROR at %0t: first result never arrived after reset", $time);
    end else if (cycles != PipeLatency) begin
      errOther++;
      $display("FAIL at %0t: outVld latency expected %0d actual %0d", $time, PipeLatency, cycles);
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin : compareResults
    logic [WordWidth+1:0] exp;
    if (rstN && outVld) begin
      if (expQ.size() == 0) begin
        errOther++;
        $display("ERROR at %0t: unexpected result with no operation outstanding", $time);
      end else begin
        exp = expQ.pop_front();
        checked++;
        if (outValue !== exp[WordWidth-1:0]) begin
          errValue++;
          $display("FAIL at %0t: outValue expected %h actual %h", $time,
                   exp[WordWidth-1:0], outValue);
        end
        if (outZero !== exp[WordWidth]) begin
          errFlag++;
          $display("FAIL at %0t: outZero expected %b actual %b", $time, exp[WordWidth], outZero);
        end
        if (outNeg !== exp[WordWidth+1]) begin
          errFlag++;
          $display("FAIL at %0t: outNeg expected %b actual %b", $time, exp[WordWidth+1], outNeg);
        end
      end
    end
  end

  initial begin : mainSeq
    wordT pats[3];
    wordT rotated;
    int seed;
    seed    = $urandom(63);
    clk     = 1'b0;
    rstN    = 1'b0;
    inVld   = 1'b0;
    inValue = '0;
    inOp    = OpRotL;
    inAmt   = '0;
    pats[0] = 16'hA5C3;
    pats[1] = 16'h8001;
    pats[2] = 16'h1234;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;

    // Quiet after reset, then one strobe timed
    for (int i = 0; i < 8; i++) begin
      if (outVld) begin
        errOther++;
        $display("ERROR at %0t: outVld pulsed after reset with no input", $time);
      end
      idleCycles(1);
    end
    checkLatency(16'h00F0, OpRotL, 4'd3);
    waitDrain();

    // Full sweep, amount 0 must echo the operand
    foreach (pats[p]) begin
      for (int op = 0; op < 4; op++) begin
        for (int amt = 0; amt < 16; amt++) begin
          if (amt == 0) begin
            driveExpect(pats[p], shiftOpT'(op), shiftAmtT'(amt), pats[p]);
          end else begin
            driveOp(pats[p], shiftOpT'(op), shiftAmtT'(amt));
          end
        end
      end
    end
    waitDrain();

    // Rotate there and back
    for (int k = 1; k < 16; k++) begin
      rotated = refShift(pats[0], OpRotL, shiftAmtT'(k));
      driveOp(pats[0], OpRotL, shiftAmtT'(k));
      driveExpect(rotated, OpRotR, shiftAmtT'(k), pats[0]);
    end
    waitDrain();

    // Shifts that empty the word or leave only the top bit
    driveOp(16'hFFFE, OpShiftL, 4'd15);
    driveOp(16'h7FFF, OpShiftR, 4'd15);
    driveOp(16'h0001, OpShiftL, 4'd15);
    driveOp(16'h8000, OpShiftR, 4'd15);
    waitDrain();

    // Back-to-back random, four in flight
    repeat (200) begin
      driveOp(wordT'($urandom), shiftOpT'($urandom), shiftAmtT'($urandom));
    end
    waitDrain();

    // Random gaps
    repeat (100) begin
      driveOp(wordT'($urandom), shiftOpT'($urandom), shiftAmtT'($urandom));
      idleCycles($urandom_range(0, 3));
    end
    waitDrain();
    idleCycles(PipeLatency + 2);

    if (issued != checked) begin
      errOther++;
      $display("ERROR: %0d operations issued but %0d results seen", issued, checked);
    end
    $display("Checked %0d results: %0d value errors, %0d flag errors, %0d other errors",
             checked, errValue, errFlag, errOther);
    if (errValue + errFlag + errOther == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
shiftPkg.sv
shiftBus.sv
shiftStage.sv
shiftIssue.sv
shiftPipe.sv
shiftRetire.sv
shiftUnit.sv
shiftUnit_props.sv
shiftUnit_tb.sv

//--- Bender.yml
package:
  name: shift_unit

sources:
  - shiftPkg.sv
  - shiftBus.sv
  - shiftStage.sv
  - shiftIssue.sv
  - shiftPipe.sv
  - shiftRetire.sv
  - shiftUnit.sv
  - target: test
    files:
      - shiftUnit_props.sv
      - shiftUnit_tb.sv
